/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sa_ctrl
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test passed

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
sa_ctrl_pkg.sv
sa_ctrl_fsm.sv
sa_rom_sig_regs.sv
sa_pass_tracker.sv
sa_row_map.sv
sa_ctrl_top.sv
sa_ctrl_chk.sv
tb_sa_ctrl.sv

/* sa_ctrl_chk.sv */
`default_nettype none

module sa_ctrl_chk import sa_ctrl_pkg::*; (
    input wire clk_i,
    input wire sel_mux_tr_rst,
    input wire load_i,
    input wire start_op_i,
    input wire layer_done_i
);

    int unsigned fail_cnt = 0;
    logic [7:0]  load_run;

    // length of the current run of load cycles
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst)
            load_run <= '0;
        else if (load_i)
            load_run <= load_run + 1'b1;
        else
            load_run <= '0;
    end

    a_load_op_excl: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        !(load_i && start_op_i))
    else begin
        fail_cnt++;
        $error("load and start_op high in the same cycle");
    end

    a_done_pulse: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        layer_done_i |=> !layer_done_i)
    else begin
        fail_cnt++;
        $error("layer_done held longer than one cycle");
    end

    a_load_len: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        $fell(load_i) |-> (load_run == 8'(N_COLS)))
    else begin
        fail_cnt++;
        $error("load phase length differs from the column count");
    end

endmodule

bind sa_ctrl_fsm sa_ctrl_chk u_chk (
    .clk_i          (clk_i),
    .sel_mux_tr_rst (sel_mux_tr_rst),
    .load_i         (load_o),
    .start_op_i     (start_op_o),
    .layer_done_i   (layer_done_o)
);

`default_nettype wire

/* sa_ctrl_fsm.sv */
`default_nettype none

module sa_ctrl_fsm import sa_ctrl_pkg::*; (
    input  wire        clk_i,
    input  wire        sel_mux_tr_rst,
    input  wire        input_ready_i,
    input  wire        weight_ready_i,
    input  wire        bram_ready_i,
    input  fsize_t     filter_size_i,
    input  wire        feature_last_i,
    input  wire        channels_done_i,
    output fsm_ctrl_t  ctrl_o,
    output sa_state_e  state_o,
    output logic       array_clr_o,
    output logic       load_o,
    output logic       ready_o,
    output logic       start_op_o,
    output logic       rd_weight_ld_o,
    output logic       rd_feature_ld_o,
    output logic       rd_rom_signals_ld_o,
    output logic       layer_done_o
);

    sa_state_e          state_q;
    sa_state_e          state_d;
    logic [PHASE_W-1:0] phase_q;
    logic [PHASE_W-1:0] drain_last;
    logic               load_end;
    logic               prime_end;
    logic               drain_end;

    // drain lasts 2*(filter_size-1)+DRAIN_BASE cycles
    assign drain_last = PHASE_W'(2 * filter_size_i + DRAIN_BASE - 3);

    assign load_end  = (phase_q == PHASE_W'(N_COLS - 1));
    assign prime_end = (phase_q == PHASE_W'(PRIME_CYCLES - 1));
    assign drain_end = (phase_q == drain_last);

    assign state_o = state_q;

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, NEXT_CHAN: begin
                if (input_ready_i && weight_ready_i)
                    state_d = LOAD;
                else if (input_ready_i)
                    state_d = WAIT_WEIGHT;
            end
            WAIT_WEIGHT: if (weight_ready_i) state_d = LOAD;
            LOAD:        if (load_end) state_d = WAIT_BRAM;
            WAIT_BRAM:   if (bram_ready_i) state_d = PRIME;
            PRIME:       if (prime_end) state_d = STREAM;
            STREAM:      if (feature_last_i) state_d = DRAIN;
            DRAIN: begin
                if (drain_end)
                    state_d = channels_done_i ? IDLE : NEXT_CHAN;
            end
            default:     state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    // one counter serves load, prime and drain, restarted on every state change
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst)
            phase_q <= '0;
        else if (state_d != state_q)
            phase_q <= '0;
        else if (state_q == LOAD || state_q == PRIME || state_q == DRAIN)
            phase_q <= phase_q + 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // strobes, decoded from the next state so they line up with state_q
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            array_clr_o         <= 1'b1;
            load_o              <= 1'b0;
            ready_o             <= 1'b0;
            start_op_o          <= 1'b0;
            rd_weight_ld_o      <= 1'b0;
            rd_feature_ld_o     <= 1'b0;
            rd_rom_signals_ld_o <= 1'b0;
            layer_done_o        <= 1'b0;
            ctrl_o              <= '0;
        end else begin
            array_clr_o         <= (state_d == IDLE);
            load_o              <= (state_d == LOAD);
            ready_o             <= (state_d == PRIME);
            start_op_o          <= (state_d == STREAM) || (state_d == DRAIN);
            rd_weight_ld_o      <= (state_d == LOAD);
            rd_feature_ld_o     <= (state_d == STREAM);
            rd_rom_signals_ld_o <= (state_d == LOAD);
            // one cycle on the way back to idle
            layer_done_o        <= (state_q == DRAIN) && (state_d == IDLE);

            ctrl_o.cfg_ld       <= (state_d == IDLE);
            ctrl_o.sig_ld       <= (state_d == LOAD);
            ctrl_o.sig_clr      <= (state_d == IDLE);
            ctrl_o.feat_clr     <= (state_d == IDLE) || (state_d == PRIME);
            ctrl_o.feat_step    <= (state_d == STREAM);
            ctrl_o.drain_enter  <= (state_d == DRAIN) && (state_q != DRAIN);
            ctrl_o.pass_clr     <= (state_d == IDLE);
        end
    end

endmodule

`default_nettype wire

/* sa_ctrl_pkg.sv */
`default_nettype none

package sa_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // array geometry and field widths
    ////////////////////////////////////////////////////////////

    localparam int N_ROWS = 4;
    localparam int N_COLS = 4;
    // largest supported filter
    localparam int N_MAX  = 3;

    localparam int SEL_W       = $clog2(N_MAX);
    localparam int NCOL_W      = $clog2(N_MAX + 1);
    localparam int SIG_ADDR_W  = 10;
    localparam int FEAT_ADDR_W = 8;
    localparam int CHAN_W      = 6;

    // phase lengths
    localparam int PRIME_CYCLES = 3;
    localparam int DRAIN_BASE   = 6;

    // shared phase counter must hold the longest of load, prime and drain
    localparam int PHASE_W = $clog2(N_COLS + PRIME_CYCLES + DRAIN_BASE + 2 * N_MAX);

    ////////////////////////////////////////////////////////////
    // scalar types
    ////////////////////////////////////////////////////////////

    typedef logic [NCOL_W-1:0]      fsize_t;
    typedef logic [CHAN_W-1:0]      chan_t;
    typedef logic [FEAT_ADDR_W-1:0] feat_addr_t;
    typedef logic [SIG_ADDR_W-1:0]  sig_addr_t;
    typedef logic [NCOL_W-1:0]      ncol_t;
    typedef logic [SEL_W-1:0]       sel_t;

    ////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        fsize_t     filter_size;
        chan_t      total_channels;
        feat_addr_t num_inputs;
    } layer_cfg_t;

    // control fields for one array row
    typedef struct packed {
        sel_t  f_sel;
        ncol_t number_of_columns;
        logic  en_adder_node;
    } row_ctrl_t;

    // one ROM word, row 0 in the low bits
    typedef row_ctrl_t [N_ROWS-1:0] rom_sig_t;

    localparam int ROM_SIG_W = $bits(rom_sig_t);

    // row-map part of the geometry
    typedef struct packed {
        ncol_t row_num;
        logic  sel_mux_node;
    } row_geom_t;

    typedef struct packed {
        ncol_t row_num;
        ncol_t column_num;
        logic  sel_mux_node;
    } pe_geom_t;

    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        WAIT_WEIGHT = 3'd1,
        LOAD        = 3'd2,
        WAIT_BRAM   = 3'd3,
        PRIME       = 3'd4,
        STREAM      = 3'd5,
        DRAIN       = 3'd6,
        NEXT_CHAN   = 3'd7
    } sa_state_e;

    // strobes from the FSM to the datapath
    typedef struct packed {
        logic cfg_ld;
        logic sig_ld;
        logic sig_clr;
        logic feat_clr;
        logic feat_step;
        logic drain_enter;
        logic pass_clr;
    } fsm_ctrl_t;

endpackage

`default_nettype wire

/* sa_ctrl_top.sv */
`default_nettype none

module sa_ctrl_top import sa_ctrl_pkg::*; (
    input  wire                     clk_i,
    input  wire                     sel_mux_tr_rst,
    input  layer_cfg_t              cfg_i,
    input  rom_sig_t                rom_sig_i,
    input  wire                     input_ready_i,
    input  wire                     weight_ready_i,
    input  wire                     bram_ready_i,
    output sa_state_e               state_o,
    output logic                    array_clr_o,
    output logic                    load_o,
    output logic                    ready_o,
    output logic                    start_op_o,
    output logic                    rd_weight_ld_o,
    output logic                    rd_feature_ld_o,
    output logic                    rd_rom_signals_ld_o,
    output feat_addr_t              in_feature_addr_o,
    output sig_addr_t               addrs_rom_signal_o,
    output row_ctrl_t [N_ROWS-1:0]  row_ctrl_o,
    output pe_geom_t  [N_ROWS-1:0]  geom_o,
    output logic                    layer_done_o
);

    fsm_ctrl_t              ctrl;
    fsize_t                 filter_size;
    logic                   feature_last;
    logic                   channels_done;
    ncol_t     [N_ROWS-1:0] column_num;
    row_geom_t [N_ROWS-1:0] geom_row;

    sa_ctrl_fsm u_fsm (
        .clk_i               (clk_i),
        .sel_mux_tr_rst      (sel_mux_tr_rst),
        .input_ready_i       (input_ready_i),
        .weight_ready_i      (weight_ready_i),
        .bram_ready_i        (bram_ready_i),
        .filter_size_i       (filter_size),
        .feature_last_i      (feature_last),
        .channels_done_i     (channels_done),
        .ctrl_o              (ctrl),
        .state_o             (state_o),
        .array_clr_o         (array_clr_o),
        .load_o              (load_o),
        .ready_o             (ready_o),
        .start_op_o          (start_op_o),
        .rd_weight_ld_o      (rd_weight_ld_o),
        .rd_feature_ld_o     (rd_feature_ld_o),
        .rd_rom_signals_ld_o (rd_rom_signals_ld_o),
        .layer_done_o        (layer_done_o)
    );

    sa_rom_sig_regs u_sig_regs (
        .clk_i          (clk_i),
        .sel_mux_tr_rst (sel_mux_tr_rst),
        .ctrl_i         (ctrl),
        .rom_sig_i      (rom_sig_i),
        .row_ctrl_o     (row_ctrl_o),
        .column_num_o   (column_num)
    );

    sa_pass_tracker u_tracker (
        .clk_i              (clk_i),
        .sel_mux_tr_rst     (sel_mux_tr_rst),
        .ctrl_i             (ctrl),
        .cfg_i              (cfg_i),
        .filter_size_o      (filter_size),
        .feature_last_o     (feature_last),
        .channels_done_o    (channels_done),
        .in_feature_addr_o  (in_feature_addr_o),
        .addrs_rom_signal_o (addrs_rom_signal_o)
    );

    sa_row_map u_row_map (
        .filter_size_i (filter_size),
        .geom_row_o    (geom_row)
    );

    // geometry per row, column number from the sig regs
    for (genvar r = 0; r < N_ROWS; r++) begin : g_geom
        assign geom_o[r].row_num      = geom_row[r].row_num;
        assign geom_o[r].column_num   = column_num[r];
        assign geom_o[r].sel_mux_node = geom_row[r].sel_mux_node;
    end

endmodule

`default_nettype wire

/* sa_pass_tracker.sv */
`default_nettype none

module sa_pass_tracker import sa_ctrl_pkg::*; (
    input  wire         clk_i,
    input  wire         sel_mux_tr_rst,
    input  fsm_ctrl_t   ctrl_i,
    input  layer_cfg_t  cfg_i,
    output fsize_t      filter_size_o,
    output logic        feature_last_o,
    output logic        channels_done_o,
    output feat_addr_t  in_feature_addr_o,
    output sig_addr_t   addrs_rom_signal_o
);

    layer_cfg_t cfg_q;
    chan_t      chan_cnt_q;
    chan_t      chan_step;
    feat_addr_t feat_addr_q;
    sig_addr_t  sig_addr_q;

    // channels covered by one pass of the array
    always_comb begin
        if (cfg_q.filter_size == '0)
            chan_step = chan_t'(N_ROWS);
        else
            chan_step = chan_t'(N_ROWS / cfg_q.filter_size);
    end

    // layer configuration, followed while idle
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst)
            cfg_q <= '0;
        else if (ctrl_i.cfg_ld)
            cfg_q <= cfg_i;
    end

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst)
            chan_cnt_q <= '0;
        else if (ctrl_i.pass_clr)
            chan_cnt_q <= '0;
        else if (ctrl_i.drain_enter)
            chan_cnt_q <= chan_cnt_q + chan_step;
    end

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst)
            feat_addr_q <= '0;
        else if (ctrl_i.feat_clr)
            feat_addr_q <= '0;
        else if (ctrl_i.feat_step)
            feat_addr_q <= feat_addr_q + 1'b1;
    end

    // rom address keeps running across passes of a layer
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst)
            sig_addr_q <= '0;
        else if (ctrl_i.pass_clr)
            sig_addr_q <= '0;
        else if (ctrl_i.sig_ld)
            sig_addr_q <= sig_addr_q + 1'b1;
    end

    assign filter_size_o      = cfg_q.filter_size;
    assign feature_last_o     = (feat_addr_q == feat_addr_t'(cfg_q.num_inputs - 1'b1));
    assign channels_done_o    = (chan_cnt_q >= cfg_q.total_channels);
    assign in_feature_addr_o  = feat_addr_q;
    assign addrs_rom_signal_o = sig_addr_q;

endmodule

`default_nettype wire

/* sa_rom_sig_regs.sv */
`default_nettype none

module sa_rom_sig_regs import sa_ctrl_pkg::*; (
    input  wire                        clk_i,
    input  wire                        sel_mux_tr_rst,
    input  fsm_ctrl_t                  ctrl_i,
    input  rom_sig_t                   rom_sig_i,
    output row_ctrl_t [N_ROWS-1:0]     row_ctrl_o,
    output ncol_t     [N_ROWS-1:0]     column_num_o
);

    row_ctrl_t [N_ROWS-1:0] row_ctrl_q;
    ncol_t     [N_ROWS-1:0] column_num_q;
    ncol_t     [N_ROWS-1:0] col_cnt_q;
    ncol_t     [N_ROWS-1:0] col_wrap;

    assign row_ctrl_o   = row_ctrl_q;
    assign column_num_o = column_num_q;

    ////////////////////////////////////////////////////////////
    // per-row control fields
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            row_ctrl_q <= '0;
        end else if (ctrl_i.sig_clr) begin
            row_ctrl_q <= '0;
        end else if (ctrl_i.sig_ld) begin
            for (int r = 0; r < N_ROWS; r++) begin
                row_ctrl_q[r] <= rom_sig_i[r];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // column counters
    ////////////////////////////////////////////////////////////

    // last count before wrap, from the word being loaded
    always_comb begin
        for (int r = 0; r < N_ROWS; r++) begin
            col_wrap[r] = ncol_t'(rom_sig_i[r].number_of_columns - 1'b1);
        end
    end

    // column number counts down from number_of_columns
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            col_cnt_q    <= '0;
            column_num_q <= '0;
        end else if (ctrl_i.sig_clr) begin
            col_cnt_q    <= '0;
            column_num_q <= '0;
        end else if (ctrl_i.sig_ld) begin
            for (int r = 0; r < N_ROWS; r++) begin
                column_num_q[r] <= rom_sig_i[r].number_of_columns - col_cnt_q[r];
                if (col_cnt_q[r] == col_wrap[r])
                    col_cnt_q[r] <= '0;
                else
                    col_cnt_q[r] <= col_cnt_q[r] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* sa_row_map.sv */
`default_nettype none

module sa_row_map import sa_ctrl_pkg::*; (
    input  fsize_t                  filter_size_i,
    output row_geom_t [N_ROWS-1:0]  geom_row_o
);

    // rows are numbered 1..filter_size, repeating down the array
    always_comb begin
        fsize_t idx;

        idx = fsize_t'(1);
        for (int r = 0; r < N_ROWS; r++) begin
            geom_row_o[r].row_num      = idx;
            // last row of a filter group feeds the adder node
            geom_row_o[r].sel_mux_node = (idx != filter_size_i);
            if (idx >= filter_size_i)
                idx = fsize_t'(1);
            else
                idx = idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tb_sa_ctrl.sv */
`default_nettype none

module tb_sa_ctrl import sa_ctrl_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int N_TESTS    = 6;

    typedef struct {
        int fs;
        int chans;
        int n_in;
        int wdly;
        int bdly;
        int rom_seed;
        int passes;
    } test_t;

    // filter_size, total_channels, num_inputs, weight delay, bram delay, rom seed, passes
    test_t tests [N_TESTS] = '{
        '{1, 4, 5, 0, 0, 0,  1},
        '{2, 5, 3, 2, 1, 17, 3},
        '{3, 2, 7, 0, 3, 5,  2},
        '{1, 9, 1, 3, 0, 99, 3},
        '{2, 2, 4, 1, 2, 42, 1},
        '{3, 3, 2, 0, 0, 7,  3}
    };

    logic                   clk_i;
    logic                   sel_mux_tr_rst;
    layer_cfg_t             cfg_i;
    rom_sig_t               rom_sig_i;
    logic                   input_ready_i;
    logic                   weight_ready_i;
    logic                   bram_ready_i;
    sa_state_e              state_o;
    logic                   array_clr_o;
    logic                   load_o;
    logic                   ready_o;
    logic                   start_op_o;
    logic                   rd_weight_ld_o;
    logic                   rd_feature_ld_o;
    logic                   rd_rom_signals_ld_o;
    feat_addr_t             in_feature_addr_o;
    sig_addr_t              addrs_rom_signal_o;
    row_ctrl_t [N_ROWS-1:0] row_ctrl_o;
    pe_geom_t  [N_ROWS-1:0] geom_o;
    logic                   layer_done_o;

    integer    seed;
    int        errors;
    int        checks;
    bit        mon_en;
    int        load_cnt;
    int        prime_cnt;
    int        stream_cnt;
    int        drain_cnt;
    int        done_cnt;
    int        exp_feat;
    int        exp_rom_addr;
    int        cur_passes;
    sa_state_e prev_state;
    rom_sig_t  last_word;
    ncol_t     col_cnt [N_ROWS];
    ncol_t     exp_col [N_ROWS];

    sa_ctrl_top uut (
        .clk_i               (clk_i),
        .sel_mux_tr_rst      (sel_mux_tr_rst),
        .cfg_i               (cfg_i),
        .rom_sig_i           (rom_sig_i),
        .input_ready_i       (input_ready_i),
        .weight_ready_i      (weight_ready_i),
        .bram_ready_i        (bram_ready_i),
        .state_o             (state_o),
        .array_clr_o         (array_clr_o),
        .load_o              (load_o),
        .ready_o             (ready_o),
        .start_op_o          (start_op_o),
        .rd_weight_ld_o      (rd_weight_ld_o),
        .rd_feature_ld_o     (rd_feature_ld_o),
        .rd_rom_signals_ld_o (rd_rom_signals_ld_o),
        .in_feature_addr_o   (in_feature_addr_o),
        .addrs_rom_signal_o  (addrs_rom_signal_o),
        .row_ctrl_o          (row_ctrl_o),
        .geom_o              (geom_o),
        .layer_done_o        (layer_done_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // new rom word every cycle
    initial begin
        logic [31:0] rnd;

        forever begin
            @(posedge clk_i);
            rnd = $random(seed);
            rom_sig_i <= rnd[ROM_SIG_W-1:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // check helpers
    ////////////////////////////////////////////////////////////

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error %s exp %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("%s", msg);
            errors++;
        end
    endtask

    // pass order of the controller
    function automatic bit legal_step(input sa_state_e cur, input sa_state_e nxt);
        case (cur)
            IDLE, NEXT_CHAN: return (nxt == LOAD) || (nxt == WAIT_WEIGHT);
            WAIT_WEIGHT:     return (nxt == LOAD);
            LOAD:            return (nxt == WAIT_BRAM);
            WAIT_BRAM:       return (nxt == PRIME);
            PRIME:           return (nxt == STREAM);
            STREAM:          return (nxt == DRAIN);
            DRAIN:           return (nxt == IDLE) || (nxt == NEXT_CHAN);
            default:         return 1'b0;
        endcase
    endfunction

    task automatic check_strobes();
        check_val("array_clr_o", 32'(array_clr_o), 32'(state_o == IDLE));
        check_val("load_o", 32'(load_o), 32'(state_o == LOAD));
        check_val("rd_weight_ld_o", 32'(rd_weight_ld_o), 32'(state_o == LOAD));
        check_val("rd_rom_signals_ld_o", 32'(rd_rom_signals_ld_o), 32'(state_o == LOAD));
        check_val("ready_o", 32'(ready_o), 32'(state_o == PRIME));
        check_val("start_op_o", 32'(start_op_o), 32'(state_o == STREAM || state_o == DRAIN));
        check_val("rd_feature_ld_o", 32'(rd_feature_ld_o), 32'(state_o == STREAM));
    endtask

    // fields after load and the row map for this filter size
    task automatic check_rows(input int fs);
        for (int r = 0; r < N_ROWS; r++) begin
            check_val($sformatf("row_ctrl_o[%0d]", r), 32'(row_ctrl_o[r]), 32'(last_word[r]));
            check_val($sformatf("column_num[%0d]", r), 32'(geom_o[r].column_num),
                      32'(exp_col[r]));
            check_val($sformatf("row_num[%0d]", r), 32'(geom_o[r].row_num), 32'(r % fs + 1));
            check_val($sformatf("sel_mux_node[%0d]", r), 32'(geom_o[r].sel_mux_node),
                      32'((r % fs) != fs - 1));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // cycle monitor sampled on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        if (mon_en) begin
            if (state_o != prev_state) begin
                check_true(legal_step(prev_state, state_o),
                           $sformatf("state stepped from %s to %s out of the pass order",
                                     prev_state.name(), state_o.name()));
                prev_state = state_o;
            end
            check_strobes();
            if (load_o) begin
                check_val("addrs_rom_signal_o", 32'(addrs_rom_signal_o), 32'(exp_rom_addr));
                exp_rom_addr++;
                load_cnt++;
                last_word = rom_sig_i;
                // countdown per row with the count wrapping at number_of_columns-1
                for (int r = 0; r < N_ROWS; r++) begin
                    exp_col[r] = ncol_t'(rom_sig_i[r].number_of_columns - col_cnt[r]);
                    if (col_cnt[r] == ncol_t'(rom_sig_i[r].number_of_columns - 1'b1))
                        col_cnt[r] = '0;
                    else
                        col_cnt[r] = col_cnt[r] + 1'b1;
                end
            end
            if (ready_o)
                prime_cnt++;
            if (rd_feature_ld_o) begin
                check_val("in_feature_addr_o", 32'(in_feature_addr_o), 32'(exp_feat));
                exp_feat++;
                stream_cnt++;
            end
            if (start_op_o && !rd_feature_ld_o)
                drain_cnt++;
            if (layer_done_o) begin
                done_cnt++;
                check_val("addrs_rom_signal_o", 32'(addrs_rom_signal_o),
                          32'(cur_passes * N_COLS));
            end
            if (state_o == IDLE) begin
                exp_rom_addr = 0;
                for (int r = 0; r < N_ROWS; r++)
                    col_cnt[r] = '0;
            end
            if (state_o == PRIME)
                exp_feat = 0;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic wait_state(input sa_state_e target);
        @(negedge clk_i);
        while (state_o != target)
            @(negedge clk_i);
    endtask

    task automatic run_pass(input test_t tc, output sa_state_e end_state);
        @(posedge clk_i);
        load_cnt   = 0;
        prime_cnt  = 0;
        stream_cnt = 0;
        drain_cnt  = 0;
        input_ready_i  <= 1'b1;
        weight_ready_i <= (tc.wdly == 0);
        bram_ready_i   <= (tc.bdly == 0);
        if (tc.wdly > 0) begin
            wait_state(WAIT_WEIGHT);
            repeat (tc.wdly) begin
                check_val("state_o", 32'(state_o), 32'(WAIT_WEIGHT));
                check_val("load_o", 32'(load_o), 32'd0);
                check_val("ready_o", 32'(ready_o), 32'd0);
                @(negedge clk_i);
            end
            @(posedge clk_i);
            weight_ready_i <= 1'b1;
        end
        wait_state(LOAD);
        // dropping these mid-load must not matter
        @(posedge clk_i);
        input_ready_i  <= 1'b0;
        weight_ready_i <= 1'b0;
        wait_state(WAIT_BRAM);
        check_rows(tc.fs);
        if (tc.bdly > 0) begin
            repeat (tc.bdly) begin
                check_val("state_o", 32'(state_o), 32'(WAIT_BRAM));
                check_val("load_o", 32'(load_o), 32'd0);
                check_val("ready_o", 32'(ready_o), 32'd0);
                @(negedge clk_i);
            end
            @(posedge clk_i);
            bram_ready_i <= 1'b1;
        end
        wait_state(PRIME);
        @(posedge clk_i);
        bram_ready_i <= 1'b0;
        @(negedge clk_i);
        while (state_o != IDLE && state_o != NEXT_CHAN)
            @(negedge clk_i);
        end_state = state_o;
    endtask

    task automatic run_layer(input test_t tc);
        sa_state_e end_state;

        @(negedge clk_i);
        seed = 32'hc5fc_fbd4 ^ tc.rom_seed;
        @(posedge clk_i);
        cfg_i <= '{filter_size: fsize_t'(tc.fs), total_channels: chan_t'(tc.chans),
                   num_inputs: feat_addr_t'(tc.n_in)};
        cur_passes = tc.passes;
        done_cnt   = 0;
        // one idle cycle to capture the config
        @(posedge clk_i);
        for (int p = 0; p < tc.passes; p++) begin
            run_pass(tc, end_state);
            @(posedge clk_i);
            check_val("load_o cycles", 32'(load_cnt), 32'(N_COLS));
            check_val("ready_o cycles", 32'(prime_cnt), 32'(PRIME_CYCLES));
            check_val("rd_feature_ld_o cycles", 32'(stream_cnt), 32'(tc.n_in));
            check_val("drain cycles", 32'(drain_cnt), 32'(2 * (tc.fs - 1) + 6));
            if (p == tc.passes - 1)
                check_true(end_state == IDLE, "layer did not return to idle after its last pass");
            else
                check_true(end_state == NEXT_CHAN, "layer ended before all channel passes ran");
        end
        check_val("layer_done_o pulses", 32'(done_cnt), 32'd1);
    endtask

    initial begin
        sel_mux_tr_rst = 1'b1;
        cfg_i          = '0;
        rom_sig_i      = '0;
        input_ready_i  = 1'b0;
        weight_ready_i = 1'b0;
        bram_ready_i   = 1'b0;
        seed           = 32'hc5fc_fbd4;
        errors         = 0;
        checks         = 0;
        mon_en         = 1'b0;
        exp_rom_addr   = 0;
        exp_feat       = 0;
        prime_cnt      = 0;
        prev_state     = IDLE;
        for (int r = 0; r < N_ROWS; r++) begin
            col_cnt[r] = '0;
            exp_col[r] = '0;
        end
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        check_val("state_o", 32'(state_o), 32'(IDLE));
        check_val("array_clr_o", 32'(array_clr_o), 32'd1);
        check_val("load_o", 32'(load_o), 32'd0);
        check_val("ready_o", 32'(ready_o), 32'd0);
        check_val("start_op_o", 32'(start_op_o), 32'd0);
        check_val("rd_weight_ld_o", 32'(rd_weight_ld_o), 32'd0);
        check_val("rd_feature_ld_o", 32'(rd_feature_ld_o), 32'd0);
        check_val("rd_rom_signals_ld_o", 32'(rd_rom_signals_ld_o), 32'd0);
        check_val("layer_done_o", 32'(layer_done_o), 32'd0);
        @(posedge clk_i);
        sel_mux_tr_rst <= 1'b0;
        mon_en = 1'b1;
        for (int t = 0; t < N_TESTS; t++)
            run_layer(tests[t]);
        repeat (2) @(negedge clk_i);
        $display("checks %0d errors %0d assertion failures %0d", checks, errors,
                 uut.u_fsm.u_chk.fail_cnt);
        if (errors == 0 && uut.u_fsm.u_chk.fail_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // watchdog sized from the table
    initial begin
        int limit;

        limit = 100;
        for (int t = 0; t < N_TESTS; t++)
            limit += tests[t].passes * (N_COLS + tests[t].wdly + tests[t].bdly + PRIME_CYCLES
                     + tests[t].n_in + 2 * (tests[t].fs - 1) + DRAIN_BASE + 4);
        repeat (limit + 4) @(posedge clk_i);
        $display("timeout: the layers did not finish within %0d cycles", limit);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
